/* int_div_defines.svh */
/* integer divider parameters
   operand width and function bit encoding */

`ifndef INT_DIV_DEFINES_SVH
`define INT_DIV_DEFINES_SVH

// ----------------------------------------
// datapath width
// ----------------------------------------

// operand, quotient and remainder width
`define DIV_WIDTH 32

// ----------------------------------------
// function bit encoding
// ----------------------------------------

// plain magnitude division
`define DIV_FN_UNSIGNED 1'b0
// two's complement division
`define DIV_FN_SIGNED   1'b1

`endif

/* int_div_pkg.sv */
/* integer divider types
   word, function and result types shared by all stages */

`include "int_div_defines.svh"

package int_div_pkg;

  // ----------------------------------------
  // word types
  // ----------------------------------------

  // one operand, quotient or remainder
  typedef logic [`DIV_WIDTH-1:0] div_word_t;

  // function select, one bit
  typedef enum logic {
    div_unsigned = `DIV_FN_UNSIGNED,
    div_signed   = `DIV_FN_SIGNED
  } div_fn_e;

  // ----------------------------------------
  // response word
  // ----------------------------------------

  // remainder in the high half
  typedef struct packed {
    div_word_t rem;
    div_word_t quot;
  } div_result_t;

endpackage

/* int_div_ifs.sv */
/* divider stage links
   decode to execute and execute to result, valid/ready handshakes */

`timescale 1ns/1ps

// ----------------------------------------
// decode -> execute
// ----------------------------------------

interface div_operand_if;

  // handshake
  logic valid;
  logic ready;

  // operand magnitudes
  int_div_pkg::div_word_t mag_a;
  int_div_pkg::div_word_t mag_b;

  // result sign flags
  logic neg_quot;
  logic neg_rem;

  // decode side
  modport producer (output valid, mag_a, mag_b, neg_quot, neg_rem, input ready);

  // execute side
  modport consumer (input valid, mag_a, mag_b, neg_quot, neg_rem, output ready);

endinterface

// ----------------------------------------
// execute -> result
// ----------------------------------------

interface div_raw_if;

  // handshake
  logic valid;
  logic ready;

  // unsigned quotient and remainder
  int_div_pkg::div_word_t quot;
  int_div_pkg::div_word_t rem;

  // sign flags, carried from decode
  logic neg_quot;
  logic neg_rem;

  // execute side
  modport producer (output valid, quot, rem, neg_quot, neg_rem, input ready);

  // result side
  modport consumer (input valid, quot, rem, neg_quot, neg_rem, output ready);

endinterface

/* div_operand_decode.sv */
/* divider decode stage
   registers a request, forms operand magnitudes and result sign flags */

`timescale 1ns/1ps

`include "int_div_defines.svh"

module div_operand_decode (
  input  logic                   clk,
  input  logic                   reset,
  input  int_div_pkg::div_fn_e   req_fn,
  input  int_div_pkg::div_word_t req_a,
  input  int_div_pkg::div_word_t req_b,
  input  logic                   req_val,
  output logic                   req_rdy,
  div_operand_if.producer        op
);

  logic                   is_signed;
  logic                   sign_a;
  logic                   sign_b;
  logic                   b_zero;
  int_div_pkg::div_word_t abs_a;
  int_div_pkg::div_word_t abs_b;
  logic                   accept;
  logic                   slot_val;

  // ----------------------------------------
  // sign extraction
  // ----------------------------------------

  assign is_signed = (req_fn == int_div_pkg::div_signed);

  // sign bits only count in signed mode
  assign sign_a = is_signed & req_a[`DIV_WIDTH-1];
  assign sign_b = is_signed & req_b[`DIV_WIDTH-1];

  // zero divisor keeps the quotient positive
  assign b_zero = (req_b == '0);

  // magnitudes
  // most negative value wraps to itself, read as unsigned later
  assign abs_a = sign_a ? -req_a : req_a;
  assign abs_b = sign_b ? -req_b : req_b;

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  // slot empty, or emptied by execute this cycle
  assign req_rdy = ~slot_val | op.ready;
  assign accept  = req_val & req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      slot_val <= 1'b0;
    end else if (accept) begin
      // refill, possibly in the same cycle it drains
      slot_val <= 1'b1;
    end else if (op.ready) begin
      // drained with nothing new behind it
      slot_val <= 1'b0;
    end
  end

  assign op.valid = slot_val;

  // ----------------------------------------
  // operand register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      op.mag_a    <= abs_a;
      op.mag_b    <= abs_b;
      // quotient negative when signs differ
      op.neg_quot <= (sign_a ^ sign_b) & ~b_zero;
      // remainder follows the dividend
      op.neg_rem  <= sign_a;
    end
  end

endmodule

/* div_iter_execute.sv */
/* divider execute stage
   restoring shift-subtract division, one quotient bit per cycle */

`timescale 1ns/1ps

`include "int_div_defines.svh"

module div_iter_execute (
  input  logic            clk,
  input  logic            reset,
  div_operand_if.consumer op,
  div_raw_if.producer     raw
);

  // step counter covers 0 .. DIV_WIDTH-1
  localparam int unsigned        CNT_W     = $clog2(`DIV_WIDTH);
  localparam logic [CNT_W-1:0]   LAST_STEP = CNT_W'(`DIV_WIDTH - 1);

  // partial remainder, one guard bit for the sign of the difference
  logic [`DIV_WIDTH:0]    rem_q;
  // dividend bits out at the top, quotient bits in at the bottom
  int_div_pkg::div_word_t quot_q;
  int_div_pkg::div_word_t dvsr_q;
  logic [CNT_W-1:0]       step_q;
  logic                   busy_q;
  logic                   done_q;
  logic                   neg_quot_q;
  logic                   neg_rem_q;

  logic [`DIV_WIDTH:0]    rem_shift;
  logic [`DIV_WIDTH:0]    rem_diff;
  logic                   fits;
  logic                   load;

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  // idle only, no overlap with a held result
  assign op.ready = ~busy_q & ~done_q;
  assign load     = op.valid & op.ready;

  // ----------------------------------------
  // one division step
  // ----------------------------------------

  // bring down next dividend bit
  assign rem_shift = {rem_q[`DIV_WIDTH-1:0], quot_q[`DIV_WIDTH-1]};
  assign rem_diff  = rem_shift - {1'b0, dvsr_q};

  // non-negative difference -> quotient bit is one
  assign fits = ~rem_diff[`DIV_WIDTH];

  // ----------------------------------------
  // control
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      step_q <= '0;
    end else if (load) begin
      busy_q <= 1'b1;
      step_q <= '0;
    end else if (busy_q) begin
      step_q <= step_q + 1'b1;
      // last iteration, result valid from the next cycle
      if (step_q == LAST_STEP) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end else if (raw.ready) begin
      // result taken by the result stage
      done_q <= 1'b0;
    end
  end

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      rem_q      <= '0;
      quot_q     <= op.mag_a;
      dvsr_q     <= op.mag_b;
      neg_quot_q <= op.neg_quot;
      neg_rem_q  <= op.neg_rem;
    end else if (busy_q) begin
      // keep difference or restore
      rem_q  <= fits ? rem_diff : rem_shift;
      quot_q <= {quot_q[`DIV_WIDTH-2:0], fits};
    end
  end

  // zero divisor: every step fits, so all ones and rem = dividend

  assign raw.valid    = done_q;
  assign raw.quot     = quot_q;
  assign raw.rem      = rem_q[`DIV_WIDTH-1:0];
  assign raw.neg_quot = neg_quot_q;
  assign raw.neg_rem  = neg_rem_q;

endmodule

/* div_result_sign.sv */
/* divider result stage
   applies result signs and holds the response for the consumer */

`timescale 1ns/1ps

module div_result_sign (
  input  logic                     clk,
  input  logic                     reset,
  div_raw_if.consumer              raw,
  output int_div_pkg::div_result_t resp_result,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  int_div_pkg::div_word_t quot_fix;
  int_div_pkg::div_word_t rem_fix;
  logic                   take;

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  // empty, or current response leaves this cycle
  assign raw.ready = ~resp_val | resp_rdy;
  assign take      = raw.valid & raw.ready;

  // ----------------------------------------
  // sign correction
  // ----------------------------------------

  // two's complement negate per flag
  assign quot_fix = raw.neg_quot ? -raw.quot : raw.quot;
  assign rem_fix  = raw.neg_rem ? -raw.rem : raw.rem;

  // ----------------------------------------
  // response register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (take) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      // consumed, nothing behind it
      resp_val <= 1'b0;
    end
  end

  // held while resp_rdy low
  always_ff @(posedge clk) begin
    if (take) begin
      resp_result.rem  <= rem_fix;
      resp_result.quot <= quot_fix;
    end
  end

endmodule

/* int_div_iterative.sv */
/* iterative integer divider, top level
   decode, execute and result stages behind plain valid/ready ports */

`timescale 1ns/1ps

`include "int_div_defines.svh"

module int_div_iterative (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_fn,
  input  logic [`DIV_WIDTH-1:0]     req_a,
  input  logic [`DIV_WIDTH-1:0]     req_b,
  input  logic                      req_val,
  output logic                      req_rdy,
  output logic [2*`DIV_WIDTH-1:0]   resp_result,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  // ----------------------------------------
  // boundary casts
  // ----------------------------------------

  int_div_pkg::div_fn_e     fn_s;
  int_div_pkg::div_word_t   a_s;
  int_div_pkg::div_word_t   b_s;
  int_div_pkg::div_result_t result_s;

  assign fn_s        = int_div_pkg::div_fn_e'(req_fn);
  assign a_s         = int_div_pkg::div_word_t'(req_a);
  assign b_s         = int_div_pkg::div_word_t'(req_b);
  // {rem, quot} flattened
  assign resp_result = result_s;

  // ----------------------------------------
  // stage links
  // ----------------------------------------

  div_operand_if op_if_i ();
  div_raw_if     raw_if_i ();

  // ----------------------------------------
  // stages
  // ----------------------------------------

  // magnitudes and sign flags
  div_operand_decode decode_i (
    .clk     (clk),
    .reset   (reset),
    .req_fn  (fn_s),
    .req_a   (a_s),
    .req_b   (b_s),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .op      (op_if_i.producer)
  );

  // DIV_WIDTH iterations per request
  div_iter_execute execute_i (
    .clk   (clk),
    .reset (reset),
    .op    (op_if_i.consumer),
    .raw   (raw_if_i.producer)
  );

  // sign fix and response hold
  div_result_sign result_i (
    .clk         (clk),
    .reset       (reset),
    .raw         (raw_if_i.consumer),
    .resp_result (result_s),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

endmodule

/* int_div_asserts.sv */
/* divider handshake assertions
   reset state and response hold rules, bound to the top level */

`timescale 1ns/1ps

`include "int_div_defines.svh"

module int_div_asserts (
  input logic                    clk,
  input logic                    reset,
  input logic                    req_rdy,
  input logic                    resp_val,
  input logic                    resp_rdy,
  input logic [2*`DIV_WIDTH-1:0] resp_result
);

  // failed assertion count
  int assert_fails = 0;

  // ----------------------------------------
  // reset state
  // ----------------------------------------

  // no response out of reset
  assert property (@(posedge clk) reset |=> !resp_val)
    else begin
      $error("resp_val high after reset");
      assert_fails++;
    end

  // decode slot empty, so requests are taken
  assert property (@(posedge clk) reset |=> req_rdy)
    else begin
      $error("req_rdy low after reset");
      assert_fails++;
    end

  // ----------------------------------------
  // response hold
  // ----------------------------------------

  // stalled response stays put
  assert property (@(posedge clk) disable iff (reset)
                   (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)))
    else begin
      $error("response changed or dropped while resp_rdy low");
      assert_fails++;
    end

  // valid data only
  assert property (@(posedge clk) disable iff (reset)
                   resp_val |-> !$isunknown(resp_result))
    else begin
      $error("resp_result unknown while resp_val high");
      assert_fails++;
    end

endmodule

bind int_div_iterative int_div_asserts asserts_i (
  .clk         (clk),
  .reset       (reset),
  .req_rdy     (req_rdy),
  .resp_val    (resp_val),
  .resp_rdy    (resp_rdy),
  .resp_result (resp_result)
);

/* int_div_tb.sv */
/* testbench for the iterative integer divider
   random and directed requests, checked against a reference model */

`timescale 1ns/1ps

`include "int_div_defines.svh"

module int_div_tb;

  localparam int W          = `DIV_WIDTH;
  localparam int WAIT_LIMIT = 400;

  logic             clk;
  logic             reset;
  logic             req_fn;
  logic [W-1:0]     req_a;
  logic [W-1:0]     req_b;
  logic             req_val;
  logic             req_rdy;
  logic [2*W-1:0]   resp_result;
  logic             resp_val;
  logic             resp_rdy;

  // expected {rem, quot} per accepted request, oldest first
  logic [2*W-1:0]   model_q[$];
  logic [31:0]      stim_state;
  logic [31:0]      bp_state;
  logic             bp_on;
  int               error_count;
  int               checked_count;
  int               tests_passed;
  int               tests_failed;

  int_div_iterative int_div_iterative_i (.*);

  always #50 clk = ~clk;

  // ----------------------------------------
  // random numbers and reference model
  // ----------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  // arithmetic shift spreads magnitudes, keeps the sign mix
  function automatic logic [W-1:0] random_operand();
    logic [31:0] r;
    logic [4:0]  sh;
    r  = next_rand();
    sh = 5'(next_rand());
    return $signed(r) >>> sh;
  endfunction

  function automatic logic [2*W-1:0] model_div(input logic fn, input logic [W-1:0] a,
                                               input logic [W-1:0] b);
    logic         sa;
    logic         sb;
    logic [W-1:0] ma;
    logic [W-1:0] mb;
    logic [W-1:0] q;
    logic [W-1:0] r;
    sa = (fn == `DIV_FN_SIGNED) && a[W-1];
    sb = (fn == `DIV_FN_SIGNED) && b[W-1];
    // zero divisor, both modes
    if (b == '0)
      return {a, {W{1'b1}}};
    // most negative by minus one
    if (fn == `DIV_FN_SIGNED && a == {1'b1, {(W-1){1'b0}}} && b == {W{1'b1}})
      return {{W{1'b0}}, a};
    ma = sa ? -a : a;
    mb = sb ? -b : b;
    q  = ma / mb;
    r  = ma % mb;
    // quotient sign from the sign mix, remainder from the dividend
    if (sa ^ sb)
      q = -q;
    if (sa)
      r = -r;
    return {r, q};
  endfunction

  // ----------------------------------------
  // monitor, sampled on the rising edge
  // ----------------------------------------

  always @(posedge clk) begin : monitor
    logic [2*W-1:0] expected;
    if (!reset) begin
      if (req_val && req_rdy)
        model_q.push_back(model_div(req_fn, req_a, req_b));
      if (resp_val && resp_rdy) begin
        assert (model_q.size() > 0) else begin
          $display("error: time %0t a response came with no request outstanding", $time);
          error_count++;
        end
        if (model_q.size() > 0) begin
          expected = model_q.pop_front();
          checked_count++;
          assert (resp_result === expected) else begin
            $display("error: time %0t resp_result expected %h actual %h",
                     $time, expected, resp_result);
            error_count++;
          end
        end
      end
    end
  end

  // ----------------------------------------
  // stimulus helpers, all called on the falling edge
  // ----------------------------------------

  task automatic flag_timeout(input string why);
    $display("timeout at %0t: %s", $time, why);
    error_count++;
  endtask

  task automatic step_backpressure();
    if (bp_on) begin
      bp_state = xorshift32(bp_state);
      // ready about three cycles in four
      resp_rdy = bp_state[0] | bp_state[1];
    end
  endtask

  task automatic drive_request(input logic fn, input logic [W-1:0] a, input logic [W-1:0] b);
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    req_val = 1'b1;
  endtask

  task automatic wait_accept();
    int   cycles;
    logic taken;
    cycles = 0;
    taken  = 1'b0;
    step_backpressure();
    while (!taken && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      taken = req_rdy;
      cycles++;
      @(negedge clk);
      step_backpressure();
    end
    if (!taken)
      flag_timeout("the divider never accepted the pending request");
  endtask

  task automatic send_request(input logic fn, input logic [W-1:0] a, input logic [W-1:0] b);
    drive_request(fn, a, b);
    wait_accept();
    req_val = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (model_q.size() > 0 && cycles < 40 * WAIT_LIMIT) begin
      @(negedge clk);
      step_backpressure();
      cycles++;
    end
    if (model_q.size() > 0)
      flag_timeout("responses still missing after the drain limit");
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      tests_passed++;
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, error_count - errors_before);
    end
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial begin : stimulus
    int   errs;
    logic taken;
    clk = 1'b0;
    reset = 1'b1;
    req_fn = `DIV_FN_UNSIGNED;
    req_a = '0;
    req_b = '0;
    req_val = 1'b0;
    resp_rdy = 1'b1;
    bp_on = 1'b0;
    stim_state = 32'd3;
    bp_state = 32'd3;
    error_count = 0;
    checked_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // 1: unsigned, no back-pressure
    errs = error_count;
    repeat (20) send_request(`DIV_FN_UNSIGNED, next_rand(), random_operand());
    wait_drain();
    report_test("unsigned random", errs);

    // 2: signed, random sign mix
    errs = error_count;
    repeat (20) send_request(`DIV_FN_SIGNED, random_operand(), random_operand());
    wait_drain();
    report_test("signed random", errs);

    // 3: zero divisor and overflow corner
    errs = error_count;
    send_request(`DIV_FN_UNSIGNED, next_rand(), '0);
    send_request(`DIV_FN_SIGNED, 32'h1234_5678, '0);
    send_request(`DIV_FN_SIGNED, 32'hdead_beef, '0);
    send_request(`DIV_FN_SIGNED, '0, '0);
    send_request(`DIV_FN_SIGNED, 32'h8000_0000, 32'hffff_ffff);
    send_request(`DIV_FN_UNSIGNED, 32'h8000_0000, 32'hffff_ffff);
    wait_drain();
    report_test("divide by zero and overflow", errs);

    // 4: random resp_rdy, requests back to back
    errs = error_count;
    bp_on = 1'b1;
    repeat (30) send_request(1'(next_rand()), random_operand(), random_operand());
    wait_drain();
    bp_on = 1'b0;
    resp_rdy = 1'b1;
    report_test("random back-pressure", errs);

    // 5: stalled output, one slot per stage
    errs = error_count;
    resp_rdy = 1'b0;
    drive_request(1'(next_rand()), random_operand(), random_operand());
    for (int i = 0; i < 120; i++) begin
      @(posedge clk);
      taken = req_rdy;
      @(negedge clk);
      if (taken)
        drive_request(1'(next_rand()), random_operand(), random_operand());
    end
    assert (model_q.size() == 3) else begin
      $display("error: time %0t requests accepted under stall expected 3 actual %0d",
               $time, model_q.size());
      error_count++;
    end
    // release, the fourth request goes in behind the others
    resp_rdy = 1'b1;
    wait_accept();
    req_val = 1'b0;
    wait_drain();
    report_test("three in flight", errs);

    $display("tests passed %0d, failed %0d, responses checked %0d",
             tests_passed, tests_failed, checked_count);
    if (int_div_iterative_i.asserts_i.assert_fails != 0)
      $display("%0d handshake assertions failed",
               int_div_iterative_i.asserts_i.assert_fails);
    if (tests_failed == 0 && error_count == 0 &&
        int_div_iterative_i.asserts_i.assert_fails == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* tb.f */
+incdir+.
int_div_pkg.sv
int_div_ifs.sv
div_operand_decode.sv
div_iter_execute.sv
div_result_sign.sv
int_div_iterative.sv
int_div_asserts.sv
int_div_tb.sv

/* Bender.yml */
package:
  name: int_div_iterative

sources:
  - include_dirs:
      - .
    files:
      - int_div_pkg.sv
      - int_div_ifs.sv
      - div_operand_decode.sv
      - div_iter_execute.sv
      - div_result_sign.sv
      - int_div_iterative.sv
  - target: test
    include_dirs:
      - .
    files:
      - int_div_asserts.sv
      - int_div_tb.sv
